/* stream_pkg.sv */
package stream_pkg;

   //--------------------------------------------------------------------------
   // Data path
   //--------------------------------------------------------------------------

   // Width of one data word on both bus sides
   localparam int DATA_W = 8;

   //--------------------------------------------------------------------------
   // Memory geometry
   //--------------------------------------------------------------------------

   // Address width of the block memory
   localparam int ADR_W = 6;

   // Depth of the block memory, one word per address
   localparam int MEM_WORDS = 1 << ADR_W;

   //--------------------------------------------------------------------------
   // Streaming window
   //--------------------------------------------------------------------------

   // First word that the address generator visits after reset or a wrap
   localparam logic [ADR_W-1:0] ADR_START = 6'd4;

   // Last word of the window, the generator wraps after this one
   localparam logic [ADR_W-1:0] ADR_LAST = 6'd43;

   // Address increment for every accepted transfer
   localparam logic [ADR_W-1:0] ADR_STEP = 6'd1;

   // Window size is (ADR_LAST - ADR_START) / ADR_STEP + 1, i.e. 40 words

endpackage

/* wb_stream.sv */
`timescale 1ns/1ns

// Streaming address generator on a pipelined Wishbone-like bus
// The requester on the slave side never drives an address
// Every strobe and both data paths pass straight through
// Only the memory address is generated here
module wb_stream (
   // System
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Slave side, from the stream requester
   input  logic                          s_cyc_i,
   input  logic                          s_stb_i,
   input  logic                          s_we_i,
   input  logic [stream_pkg::DATA_W-1:0] s_dat_i,
   output logic                          s_ack_o,
   output logic                          s_wat_o,
   output logic [stream_pkg::DATA_W-1:0] s_dat_o,

   // Master side, to the block memory
   output logic                          m_cyc_o,
   output logic                          m_stb_o,
   output logic                          m_we_o,
   output logic [stream_pkg::ADR_W-1:0]  m_adr_o,
   output logic [stream_pkg::DATA_W-1:0] m_dat_o,
   input  logic                          m_ack_i,
   input  logic                          m_wat_i,
   input  logic [stream_pkg::DATA_W-1:0] m_dat_i
);

   import stream_pkg::*;

   // Address register, the only state in this block
   logic [ADR_W-1:0] adr_q;

   // Pipelined acceptance, a transfer goes through when not stalled
   logic             inc;

   // Wrap detection and the address for the following access
   logic             wrap_adr;
   logic [ADR_W-1:0] next_adr;

   //--------------------------------------------------------------------------
   // Bus pass-through
   //--------------------------------------------------------------------------

   // Request path towards the memory
   assign m_cyc_o = s_cyc_i;
   assign m_stb_o = s_stb_i;
   assign m_we_o  = s_we_i;
   assign m_dat_o = s_dat_i;

   // Response path back to the requester
   assign s_ack_o = m_ack_i;
   assign s_wat_o = m_wat_i;
   assign s_dat_o = m_dat_i;

   //--------------------------------------------------------------------------
   // Address generation
   //--------------------------------------------------------------------------

   // No ack in the condition, the pipelined form advances on the strobe
   assign inc = m_cyc_o & m_stb_o & ~m_wat_i;

   // Back to the start of the window after its last word
   assign wrap_adr = (adr_q == ADR_LAST);
   assign next_adr = wrap_adr ? ADR_START : adr_q + ADR_STEP;

   // Advance on the accepting edge, hold through idle and wait cycles
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         adr_q <= ADR_START;
      end else if (inc) begin
         adr_q <= next_adr;
      end
   end

   // Memory sees the registered address with no extra delay
   assign m_adr_o = adr_q;

endmodule

/* stream_ram.sv */
`timescale 1ns/1ns

// Block memory with a pipelined Wishbone-like slave port
// Registered read port, one-cycle ack for each accepted transfer
// A read right after a write is held for one wait cycle
module stream_ram (
   // System
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Bus request
   input  logic                          cyc_i,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [stream_pkg::ADR_W-1:0]  adr_i,
   input  logic [stream_pkg::DATA_W-1:0] dat_i,

   // Bus response
   output logic                          ack_o,
   output logic                          wat_o,
   output logic [stream_pkg::DATA_W-1:0] dat_o
);

   import stream_pkg::*;

   //--------------------------------------------------------------------------
   // Storage and state
   //--------------------------------------------------------------------------

   // Word array, contents are undefined after power-up
   logic [DATA_W-1:0] mem [MEM_WORDS];

   // Read data register, loaded only by an accepted read
   logic [DATA_W-1:0] rdat_q;

   // Registered acknowledge
   logic              ack_q;

   // Previous cycle held an accepted write
   logic              wr_prev_q;

   // Acceptance terms for the current cycle
   logic              acc;
   logic              wr_acc;
   logic              rd_acc;

   //--------------------------------------------------------------------------
   // Turnaround wait
   //--------------------------------------------------------------------------

   // Read presented in the cycle after a write is stalled once
   // Write after write and read after read go through at full rate
   assign wat_o = wr_prev_q & cyc_i & stb_i & ~we_i;

   //--------------------------------------------------------------------------
   // Transfer acceptance
   //--------------------------------------------------------------------------

   // One transfer per cycle unless the wait is up
   assign acc    = cyc_i & stb_i & ~wat_o;
   assign wr_acc = acc & we_i;
   assign rd_acc = acc & ~we_i;

   // Remember a write for the next cycle only
   // An idle or read cycle in between clears the turnaround
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_prev_q <= 1'b0;
      end else begin
         wr_prev_q <= wr_acc;
      end
   end

   //--------------------------------------------------------------------------
   // Write port
   //--------------------------------------------------------------------------

   // Data is stored at the accepting edge
   always_ff @(posedge clk_i) begin
      if (wr_acc) begin
         mem[adr_i] <= dat_i;
      end
   end

   //--------------------------------------------------------------------------
   // Read port
   //--------------------------------------------------------------------------

   // Word sampled at the accepting edge
   // Holds its value until the next accepted read
   always_ff @(posedge clk_i) begin
      if (rd_acc) begin
         rdat_q <= mem[adr_i];
      end
   end

   assign dat_o = rdat_q;

   //--------------------------------------------------------------------------
   // Acknowledge
   //--------------------------------------------------------------------------

   // Exactly one ack in the cycle after each accepted transfer
   // Back-to-back transfers give back-to-back acks
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc;
      end
   end

   assign ack_o = ack_q;

endmodule

/* stream_sram_top.sv */
`timescale 1ns/1ns

// Streaming memory subsystem
// The requester moves words without addresses, the generator walks the
// window and the block memory serves each access
module stream_sram_top (
   // System
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Streaming slave port
   input  logic                          s_cyc_i,
   input  logic                          s_stb_i,
   input  logic                          s_we_i,
   input  logic [stream_pkg::DATA_W-1:0] s_dat_i,
   output logic                          s_ack_o,
   output logic                          s_wat_o,
   output logic [stream_pkg::DATA_W-1:0] s_dat_o
);

   import stream_pkg::*;

   //--------------------------------------------------------------------------
   // Internal memory bus
   //--------------------------------------------------------------------------

   // Request, driven by the address generator
   logic              m_cyc;
   logic              m_stb;
   logic              m_we;
   logic [ADR_W-1:0]  m_adr;
   logic [DATA_W-1:0] m_dat;

   // Response, driven by the memory
   logic              m_ack;
   logic              m_wat;
   logic [DATA_W-1:0] m_rdat;

   //--------------------------------------------------------------------------
   // Address generator
   //--------------------------------------------------------------------------

   wb_stream u_stream (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .s_cyc_i (s_cyc_i),
      .s_stb_i (s_stb_i),
      .s_we_i  (s_we_i),
      .s_dat_i (s_dat_i),
      .s_ack_o (s_ack_o),
      .s_wat_o (s_wat_o),
      .s_dat_o (s_dat_o),
      .m_cyc_o (m_cyc),
      .m_stb_o (m_stb),
      .m_we_o  (m_we),
      .m_adr_o (m_adr),
      .m_dat_o (m_dat),
      .m_ack_i (m_ack),
      .m_wat_i (m_wat),
      .m_dat_i (m_rdat)
   );

   //--------------------------------------------------------------------------
   // Block memory
   //--------------------------------------------------------------------------

   stream_ram u_ram (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .cyc_i (m_cyc),
      .stb_i (m_stb),
      .we_i  (m_we),
      .adr_i (m_adr),
      .dat_i (m_dat),
      .ack_o (m_ack),
      .wat_o (m_wat),
      .dat_o (m_rdat)
   );

endmodule

/* stream_checker.sv */
`timescale 1ns/1ns

// Scoreboard for the streaming memory
// Mirrors the memory contents and the window pointer and compares every
// response level of the DUT at each rising edge
module stream_checker (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // DUT inputs
   input  logic                          s_cyc_i,
   input  logic                          s_stb_i,
   input  logic                          s_we_i,
   input  logic [stream_pkg::DATA_W-1:0] s_dat_i,

   // DUT outputs
   input  logic                          s_ack_i,
   input  logic                          s_wat_i,
   input  logic [stream_pkg::DATA_W-1:0] s_rdat_i,

   // Results for the closing report
   output int                            data_err_o,
   output int                            ctrl_err_o,
   output int                            rd_cnt_o,
   output logic                          busy_o
);

   import stream_pkg::*;

   //--------------------------------------------------------------------------
   // Model state
   //--------------------------------------------------------------------------

   logic [DATA_W-1:0] model_mem [MEM_WORDS];
   logic [ADR_W-1:0]  model_ptr;

   // Expected read words, oldest first
   logic [DATA_W-1:0] rd_q [$];

   // Turnaround and ack bookkeeping
   logic              wr_prev = 1'b0;
   logic              ack_due = 1'b0;
   logic              rd_due  = 1'b0;
   logic              busy    = 1'b0;

   // Per-edge scratch
   logic              exp_wat;
   logic              acc;
   logic [DATA_W-1:0] exp_dat;

   int                data_err = 0;
   int                ctrl_err = 0;
   int                rd_cnt   = 0;

   assign data_err_o = data_err;
   assign ctrl_err_o = ctrl_err;
   assign rd_cnt_o   = rd_cnt;
   assign busy_o     = busy;

   // Next pointer, step through the window and wrap after its last word
   function automatic logic [ADR_W-1:0] next_ptr(input logic [ADR_W-1:0] p);
      if (p == ADR_LAST) begin
         return ADR_START;
      end
      return p + ADR_STEP;
   endfunction

   //--------------------------------------------------------------------------
   // Compare and update
   //--------------------------------------------------------------------------

   // Inputs change on the falling edge, so levels here are settled
   always @(posedge clk_i) begin
      if (rst_i) begin
         model_ptr = ADR_START;
         wr_prev   = 1'b0;
         ack_due   = 1'b0;
         rd_due    = 1'b0;
         rd_q.delete();
      end else begin
         // Wait only for a read in the cycle after an accepted write
         exp_wat = wr_prev & s_cyc_i & s_stb_i & ~s_we_i;
         if (s_wat_i !== exp_wat) begin
            $display("Fail at %0t ns: s_wat_o = %b, expected %b", $time, s_wat_i, exp_wat);
            ctrl_err++;
         end

         // One ack per transfer accepted at the previous edge
         if (s_ack_i !== ack_due) begin
            if (s_ack_i === 1'b1) begin
               $display("Fail at %0t ns: s_ack_o = %b, expected %b (ack with nothing outstanding)",
                        $time, s_ack_i, ack_due);
            end else begin
               $display("Fail at %0t ns: s_ack_o = %b, expected %b (ack missing)",
                        $time, s_ack_i, ack_due);
            end
            ctrl_err++;
         end

         // Read data is valid together with its ack
         if (ack_due && rd_due) begin
            exp_dat = rd_q.pop_front();
            rd_cnt++;
            if (s_rdat_i !== exp_dat) begin
               $display("Fail at %0t ns: s_dat_o = %h, expected %h", $time, s_rdat_i, exp_dat);
               data_err++;
            end
         end

         // Acceptance as the bus rules define it
         acc     = s_cyc_i & s_stb_i & ~exp_wat;
         ack_due = acc;
         rd_due  = acc & ~s_we_i;
         wr_prev = acc & s_we_i;
         if (acc) begin
            if (s_we_i) begin
               model_mem[model_ptr] = s_dat_i;
            end else begin
               rd_q.push_back(model_mem[model_ptr]);
            end
            model_ptr = next_ptr(model_ptr);
         end
      end
      busy = ack_due | (rd_q.size() != 0);
   end

endmodule

/* tb_stream_sram.sv */
`timescale 1ns/1ns

module tb_stream_sram;

   import stream_pkg::*;

   //--------------------------------------------------------------------------
   // Run length
   //--------------------------------------------------------------------------

   localparam int CLK_PERIOD = 40;
   localparam int N_FILL     = 40;
   localparam int N_WRAP     = 50;
   localparam int N_TURN     = 8;
   localparam int N_RAND     = 200;

   // Fill and read back, wrap writes and reads, turnaround pairs, random mix
   localparam int N_XFER     = 2 * N_FILL + N_WRAP + N_FILL + 2 * N_TURN + N_RAND;

   // Each transfer costs at most one gap and one wait cycle
   localparam int WATCHDOG_NS = CLK_PERIOD * (3 * N_XFER + 100);

   logic              clk;
   logic              rst;
   logic              s_cyc;
   logic              s_stb;
   logic              s_we;
   logic [DATA_W-1:0] s_wdat;
   logic              s_ack;
   logic              s_wat;
   logic [DATA_W-1:0] s_rdat;

   logic [31:0]       lfsr;
   int                data_err;
   int                ctrl_err;
   int                rd_cnt;
   logic              busy;
   int                run_err = 0;

   stream_sram_top i_stream_sram_top (
      .clk_i   (clk),
      .rst_i   (rst),
      .s_cyc_i (s_cyc),
      .s_stb_i (s_stb),
      .s_we_i  (s_we),
      .s_dat_i (s_wdat),
      .s_ack_o (s_ack),
      .s_wat_o (s_wat),
      .s_dat_o (s_rdat)
   );

   stream_checker u_checker (
      .clk_i      (clk),
      .rst_i      (rst),
      .s_cyc_i    (s_cyc),
      .s_stb_i    (s_stb),
      .s_we_i     (s_we),
      .s_dat_i    (s_wdat),
      .s_ack_i    (s_ack),
      .s_wat_i    (s_wat),
      .s_rdat_i   (s_rdat),
      .data_err_o (data_err),
      .ctrl_err_o (ctrl_err),
      .rd_cnt_o   (rd_cnt),
      .busy_o     (busy)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //--------------------------------------------------------------------------
   // Stimulus helpers
   //--------------------------------------------------------------------------

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // Present one transfer and hold it through any wait cycle
   task automatic xfer(input logic is_write, input logic [DATA_W-1:0] wdat);
      logic done;
      @(negedge clk);
      s_cyc  = 1'b1;
      s_stb  = 1'b1;
      s_we   = is_write;
      s_wdat = wdat;
      done   = 1'b0;
      while (!done) begin
         @(posedge clk);
         done = ~s_wat;
      end
   endtask

   // Idle cycle with either cyc dropped and stb left high or a strobe gap
   task automatic idle(input logic drop_cyc);
      @(negedge clk);
      s_cyc = ~drop_cyc;
      s_stb = drop_cyc;
      s_we  = 1'b0;
      @(posedge clk);
   endtask

   //--------------------------------------------------------------------------
   // Test sequence
   //--------------------------------------------------------------------------

   initial begin
      logic [31:0] r;
      logic [31:0] gap;
      logic        rand_we;
      lfsr   = 32'h877b3d30;
      rst    = 1'b1;
      s_cyc  = 1'b0;
      s_stb  = 1'b0;
      s_we   = 1'b0;
      s_wdat = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset levels with ack and wait expected low
      idle(1'b1);
      idle(1'b0);

      // Fill the window, then read it back in order from ADR_START
      for (int i = 0; i < N_FILL; i++) begin
         take_bits(DATA_W, r);
         xfer(1'b1, r[DATA_W-1:0]);
      end
      for (int i = 0; i < N_FILL; i++) begin
         xfer(1'b0, '0);
      end

      // Overrun the window so the 41st write lands on ADR_START
      for (int i = 0; i < N_WRAP; i++) begin
         take_bits(DATA_W, r);
         xfer(1'b1, r[DATA_W-1:0]);
      end
      for (int i = 0; i < N_FILL; i++) begin
         xfer(1'b0, '0);
      end

      // Read straight after write sees one wait cycle each time
      for (int i = 0; i < N_TURN; i++) begin
         take_bits(DATA_W, r);
         xfer(1'b1, r[DATA_W-1:0]);
         xfer(1'b0, '0);
      end

      // Random mix with idle gaps
      for (int i = 0; i < N_RAND; i++) begin
         take_bits(2, gap);
         if (gap[1:0] == 2'd0) begin
            idle(1'b1);
         end else if (gap[1:0] == 2'd1) begin
            idle(1'b0);
         end
         take_bits(1, r);
         rand_we = r[0];
         take_bits(DATA_W, r);
         xfer(rand_we, r[DATA_W-1:0]);
      end

      // Drain the last ack
      repeat (3) idle(1'b1);

      if (busy) begin
         $display("Error: a transfer was still outstanding at the end of the run");
         run_err++;
      end
      if (rd_cnt == 0) begin
         $display("Error: no read data was compared during the run");
         run_err++;
      end
      $display("Reads compared %0d, data errors %0d, control errors %0d, run errors %0d",
               rd_cnt, data_err, ctrl_err, run_err);
      if (data_err + ctrl_err + run_err == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Error: watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("Some tests failed");
      $finish;
   end

endmodule

/* src.f */
stream_pkg.sv
wb_stream.sv
stream_ram.sv
stream_sram_top.sv
stream_checker.sv
tb_stream_sram.sv

/* Makefile */
# Verilator build, run, lint and clean for the streaming memory

VERILATOR ?= verilator
TOP       ?= tb_stream_sram
RTL_TOP   ?= stream_sram_top
FILELIST  ?= src.f
RTL_SRCS  ?= stream_pkg.sv wb_stream.sv stream_ram.sv stream_sram_top.sv
BUILD_DIR ?= obj_dir
BIN       ?= V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(BIN)

run: build
	./$(BUILD_DIR)/$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
